/* build.f */
logic/icache_pkg.sv
logic/icache_req_stage.sv
logic/icache_tagv.sv
logic/icache_data.sv
logic/icache_lru.sv
logic/icache_ctrl.sv
logic/icache_fetch_select.sv
logic/icache_top.sv
dv/tb_icache.sv

/* dv/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    localparam int requests      = 400;
    localparam int timeout_limit = requests * 12;

    logic         clk;
    logic         rstn;
    logic         fetch_valid;
    logic [31:0]  fetch_vaddr;
    logic [31:0]  fetch_paddr;
    logic         fetch_uncached;
    logic         fetch_hold;
    logic         op_valid;
    logic [3:0]   op_index;
    logic         op_done;
    logic         rsp_valid;
    logic [31:0]  rsp_pc;
    logic [63:0]  rsp_data;
    logic         rsp_pair;
    logic         busy;
    logic         mem_req;
    logic [31:0]  mem_addr;
    logic         mem_uncached;
    logic [127:0] mem_line;
    logic         mem_data_ok;

    // reference cache state, 16 sets of 2 ways
    logic [23:0] m_tag [16][2];
    logic        m_valid [16][2];
    logic        m_lru [16];

    logic [31:0] lfsr;
    int          errors;
    int          hits;
    int          misses;
    int          cycles;
    logic        last_hit;
    logic [63:0] last_data;
    logic        last_pair;
    logic [31:0] prev_va;

    icache_top UUT (
        .clk            (clk),
        .rstn           (rstn),
        .fetch_valid    (fetch_valid),
        .fetch_vaddr    (fetch_vaddr),
        .fetch_paddr    (fetch_paddr),
        .fetch_uncached (fetch_uncached),
        .fetch_hold     (fetch_hold),
        .op_valid       (op_valid),
        .op_index       (op_index),
        .op_done        (op_done),
        .rsp_valid      (rsp_valid),
        .rsp_pc         (rsp_pc),
        .rsp_data       (rsp_data),
        .rsp_pair       (rsp_pair),
        .busy           (busy),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_uncached   (mem_uncached),
        .mem_line       (mem_line),
        .mem_data_ok    (mem_data_ok)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles, %0d errors so far",
                     timeout_limit, errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // memory content at a word address
    function automatic logic [31:0] mem_word(input logic [31:0] waddr);
        return waddr * 32'h9E37_79B1;
    endfunction

    function automatic logic [127:0] line_at(input logic [31:0] baddr);
        logic [127:0] l;
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = mem_word((baddr >> 2) + 32'(i));
        end
        return l;
    endfunction

    task automatic note_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        errors++;
        $display("FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic check_response(input logic [31:0] va, input logic [63:0] exp_data,
                                  input logic exp_pair);
        if (rsp_pc !== va)
            note_mismatch("rsp_pc", rsp_pc, va);
        if (rsp_data !== exp_data)
            note_mismatch("rsp_data", rsp_data, exp_data);
        if (rsp_pair !== exp_pair)
            note_mismatch("rsp_pair", rsp_pair, exp_pair);
        if (op_done !== 1'b0)
            note_mismatch("op_done", op_done, 0);
    endtask

    ////////////////////
    // transactions
    ////////////////////

    // entered on a falling edge with busy low, returns on a falling edge
    task automatic fetch_and_check(input logic [31:0] va, input logic unc);
        logic [31:0] pa;
        logic [3:0]  set;
        logic [23:0] tag;
        logic        hit;
        logic        way;
        logic        vict;
        logic [31:0] exp_addr;
        logic [63:0] exp_data;
        logic        exp_pair;
        int          lat;
        pa  = va ^ 32'h8000_0000;
        set = va[7:4];
        tag = pa[31:8];
        hit = 1'b0;
        way = 1'b0;
        if (m_valid[set][0] && m_tag[set][0] == tag)
            hit = 1'b1;
        if (m_valid[set][1] && m_tag[set][1] == tag) begin
            hit = 1'b1;
            way = 1'b1;
        end
        // uncached always goes out to memory
        hit      = hit && !unc;
        exp_pair = !unc && !va[2];
        exp_data = {32'h0, mem_word(pa >> 2)};
        if (exp_pair)
            exp_data[63:32] = mem_word((pa >> 2) + 32'd1);
        exp_addr = unc ? {pa[31:2], 2'b00} : {pa[31:4], 4'h0};

        fetch_valid    = 1'b1;
        fetch_vaddr    = va;
        fetch_paddr    = pa;
        fetch_uncached = unc;
        @(negedge clk);
        fetch_valid = 1'b0;
        if (hit) begin
            hits++;
            if (rsp_valid !== 1'b1)
                note_mismatch("rsp_valid", rsp_valid, 1);
            if (mem_req !== 1'b0)
                note_mismatch("mem_req", mem_req, 0);
            check_response(va, exp_data, exp_pair);
            m_lru[set] = !way;
        end else begin
            misses++;
            lat = int'(take_bits(3) % 6) + 1;
            repeat (lat) begin
                if (mem_req !== 1'b1)
                    note_mismatch("mem_req", mem_req, 1);
                if (busy !== 1'b1)
                    note_mismatch("busy", busy, 1);
                if (rsp_valid !== 1'b0)
                    note_mismatch("rsp_valid", rsp_valid, 0);
                if (mem_addr !== exp_addr)
                    note_mismatch("mem_addr", mem_addr, exp_addr);
                if (mem_uncached !== unc)
                    note_mismatch("mem_uncached", mem_uncached, unc);
                @(negedge clk);
            end
            // memory answers, response is forwarded in this cycle
            mem_line    = line_at(exp_addr);
            mem_data_ok = 1'b1;
            #2;
            if (rsp_valid !== 1'b1)
                note_mismatch("rsp_valid", rsp_valid, 1);
            check_response(va, exp_data, exp_pair);
            if (!unc) begin
                // empty way first, then the lru way
                vict = m_valid[set][0] ? (m_valid[set][1] ? m_lru[set] : 1'b1) : 1'b0;
                m_tag[set][vict]   = tag;
                m_valid[set][vict] = 1'b1;
                m_lru[set]         = !vict;
            end
            @(negedge clk);
            mem_data_ok = 1'b0;
            if (busy !== 1'b0)
                note_mismatch("busy", busy, 0);
            if (rsp_valid !== 1'b0)
                note_mismatch("rsp_valid", rsp_valid, 0);
        end
        last_hit  = hit;
        last_data = exp_data;
        last_pair = exp_pair;
        prev_va   = va;
    endtask

    // fetch stage stalls from the cycle after a hit response with a fetch pending
    task automatic stall_after_hit(input int n);
        fetch_valid = 1'b0;
        fetch_vaddr = prev_va + 32'h10;
        fetch_paddr = fetch_vaddr ^ 32'h8000_0000;
        for (int i = 0; i <= n; i++) begin
            @(negedge clk);
            if (rsp_valid !== 1'b0)
                note_mismatch("rsp_valid", rsp_valid, 0);
            if (mem_req !== 1'b0)
                note_mismatch("mem_req", mem_req, 0);
            if (i < n) begin
                fetch_hold  = 1'b1;
                fetch_valid = 1'b1;
                #2;
                if (rsp_data !== last_data)
                    note_mismatch("rsp_data", rsp_data, last_data);
                if (rsp_pair !== last_pair)
                    note_mismatch("rsp_pair", rsp_pair, last_pair);
            end
        end
        fetch_hold  = 1'b0;
        fetch_valid = 1'b0;
        last_hit    = 1'b0;
    endtask

    task automatic invalidate_set(input logic [3:0] idx);
        op_valid    = 1'b1;
        op_index    = idx;
        fetch_valid = 1'b0;
        @(negedge clk);
        op_valid = 1'b0;
        if (op_done !== 1'b1)
            note_mismatch("op_done", op_done, 1);
        if (rsp_valid !== 1'b0)
            note_mismatch("rsp_valid", rsp_valid, 0);
        m_valid[idx][0] = 1'b0;
        m_valid[idx][1] = 1'b0;
        last_hit        = 1'b0;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        logic [31:0] va;
        logic        unc;
        logic [2:0]  t;
        logic [2:0]  s;
        logic [1:0]  o;
        rstn           = 1'b0;
        fetch_valid    = 1'b0;
        fetch_vaddr    = '0;
        fetch_paddr    = '0;
        fetch_uncached = 1'b0;
        fetch_hold     = 1'b0;
        op_valid       = 1'b0;
        op_index       = '0;
        mem_line       = '0;
        mem_data_ok    = 1'b0;
        lfsr           = 32'd52;
        errors         = 0;
        hits           = 0;
        misses         = 0;
        cycles         = 0;
        last_hit       = 1'b0;
        last_data      = '0;
        last_pair      = 1'b0;
        prev_va        = 32'h0040_0000;
        for (int i = 0; i < 16; i++) begin
            m_valid[i][0] = 1'b0;
            m_valid[i][1] = 1'b0;
            m_lru[i]      = 1'b0;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (busy !== 1'b0)
            note_mismatch("busy", busy, 0);
        if (mem_req !== 1'b0)
            note_mismatch("mem_req", mem_req, 0);
        if (rsp_valid !== 1'b0)
            note_mismatch("rsp_valid", rsp_valid, 0);
        if (op_done !== 1'b0)
            note_mismatch("op_done", op_done, 0);

        for (int n = 0; n < requests; n++) begin
            if (take_bits(4) == 0) begin
                s = 3'(take_bits(3));
                invalidate_set({1'b0, s});
            end else begin
                if (take_bits(1) == 1) begin
                    // another word of the previous line
                    o  = 2'(take_bits(2));
                    va = {prev_va[31:4], o, 2'b00};
                end else begin
                    // 8 tags over 8 sets
                    t  = 3'(take_bits(3));
                    s  = 3'(take_bits(3));
                    o  = 2'(take_bits(2));
                    va = {20'h00400, 1'b0, t, 1'b0, s, o, 2'b00};
                end
                unc = (take_bits(3) == 0);
                fetch_and_check(va, unc);
                if (last_hit && take_bits(2) == 0)
                    stall_after_hit(int'(take_bits(2)) + 1);
            end
        end

        @(negedge clk);
        if (busy !== 1'b0 || mem_req !== 1'b0) begin
            errors++;
            $display("cache still busy or requesting memory after the last fetch");
        end
        $display("errors: %0d  hits: %0d  misses: %0d", errors, hits, misses);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* logic/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; #(
    parameter int index_width  = index_width_def,
    parameter int offset_width = offset_width_def
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   fetch_valid,
    input  logic                   fetch_hold,
    input  logic                   op_valid,
    input  logic [index_width-1:0] op_index,
    input  logic [addr_w-1:0]      req_vaddr,
    input  logic [addr_w-1:0]      req_paddr,
    input  logic                   req_uncached,
    input  logic [ways-1:0]        hit,
    input  logic [ways-1:0]        valid_bits,
    input  logic                   victim,
    output logic                   accept,
    output logic                   busy,
    output logic                   rsp_valid,
    output logic                   op_done,
    output logic                   mem_req,
    output logic [addr_w-1:0]      mem_addr,
    output logic                   mem_uncached,
    input  logic                   mem_data_ok,
    output logic [ways-1:0]        fill_en,
    output logic                   use_en,
    output logic                   used_way,
    output logic                   inv_en,
    output logic                   choose_return,
    output logic                   choose_way
);

    localparam int line_lsb = offset_width + 2;
    localparam int set_msb  = line_lsb + index_width - 1;

    typedef enum logic [1:0] {s_idle, s_look, s_wait, s_inv} state_t;

    state_t state;
    state_t state_nxt;
    logic   look_hit;
    logic   look_mem;
    logic   mem_done;
    logic   op_acc;
    logic   pick_way;
    logic   fill_way;

    ////////////////////
    // lookup decision
    ////////////////////

    assign look_hit = (state == s_look) && !req_uncached && (|hit);
    // miss or uncached
    assign look_mem = (state == s_look) && !look_hit;
    assign mem_done = (state == s_wait) && mem_data_ok;

    // empty way first, way 0 before way 1
    always_comb begin
        if (!valid_bits[0]) begin
            pick_way = 1'b0;
        end else if (!valid_bits[1]) begin
            pick_way = 1'b1;
        end else begin
            pick_way = victim;
        end
    end

    assign busy   = look_mem || (state == s_wait);
    assign accept = fetch_valid && !busy && !fetch_hold;
    // fetch wins over a cache op
    assign op_acc = op_valid && !fetch_valid && !busy && !fetch_hold;

    ////////////////////
    // state machine
    ////////////////////

    always_comb begin
        state_nxt = s_idle;
        if (look_mem) begin
            state_nxt = s_wait;
        end else if ((state == s_wait) && !mem_data_ok) begin
            state_nxt = s_wait;
        end else if (accept) begin
            state_nxt = s_look;
        end else if (op_acc) begin
            state_nxt = s_inv;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= s_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // victim fixed at miss time
    always_ff @(posedge clk) begin
        if (look_mem) begin
            fill_way <= pick_way;
        end
    end

    ////////////////////
    // outputs
    ////////////////////

    assign rsp_valid = look_hit || mem_done;
    assign op_done   = (state == s_inv);
    // both valid bits of the set drop on the accept edge
    assign inv_en    = op_acc;

    assign mem_req      = busy;
    assign mem_uncached = req_uncached;
    assign mem_addr     = req_uncached ? {req_paddr[addr_w-1:2], 2'b00}
                                       : {req_paddr[addr_w-1:line_lsb], {line_lsb{1'b0}}};

    // no fill for uncached data
    assign fill_en  = (mem_done && !req_uncached) ? {fill_way, !fill_way} : '0;
    assign use_en   = look_hit || (mem_done && !req_uncached);
    assign used_way = (state == s_wait) ? fill_way : hit[1];

    assign choose_return = (state == s_wait);
    assign choose_way    = hit[1];

    a_mem_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        mem_req && !mem_data_ok |=> mem_req && $stable(mem_addr)
    );

    // arrays are indexed virtually and filled at the same set
    a_index_alias: assert property (
        @(posedge clk) disable iff (!rstn)
        (state == s_look) |-> (req_vaddr[set_msb:0] == req_paddr[set_msb:0])
    );

    a_op_index_known: assert property (
        @(posedge clk) disable iff (!rstn)
        op_acc |-> !$isunknown(op_index)
    );

endmodule

/* logic/icache_data.sv */
`timescale 1ns/1ps

module icache_data import icache_pkg::*; #(
    parameter  int index_width  = index_width_def,
    parameter  int offset_width = offset_width_def,
    localparam int line_w       = word_w << offset_width
) (
    input  logic                   clk,
    input  logic [index_width-1:0] rd_index,
    output logic [line_w-1:0]      rd_line0,
    output logic [line_w-1:0]      rd_line1,
    input  logic [ways-1:0]        wr_en,
    input  logic [index_width-1:0] wr_index,
    input  logic [line_w-1:0]      wr_line
);

    localparam int sets = 1 << index_width;

    logic [line_w-1:0] rd_line [ways];

    for (genvar w = 0; w < ways; w++) begin : g_way
        logic [line_w-1:0] line_mem [sets];

        // whole line written on refill
        always_ff @(posedge clk) begin
            rd_line[w] <= line_mem[rd_index];
            if (wr_en[w]) begin
                line_mem[wr_index] <= wr_line;
            end
        end
    end

    assign rd_line0 = rd_line[0];
    assign rd_line1 = rd_line[1];

endmodule

/* logic/icache_fetch_select.sv */
`timescale 1ns/1ps

module icache_fetch_select import icache_pkg::*; #(
    parameter  int offset_width = offset_width_def,
    localparam int line_w       = word_w << offset_width
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              fetch_hold,
    input  logic              rsp_valid,
    input  logic              choose_return,
    input  logic              choose_way,
    input  logic [addr_w-1:0] req_vaddr,
    input  logic              req_uncached,
    input  logic [line_w-1:0] rd_line0,
    input  logic [line_w-1:0] rd_line1,
    input  logic [line_w-1:0] mem_line,
    output logic [addr_w-1:0] rsp_pc,
    output logic [pair_w-1:0] rsp_data,
    output logic              rsp_pair
);

    logic [line_w-1:0]       line;
    logic [offset_width-1:0] word_sel;
    logic [offset_width-1:0] next_sel;
    logic [word_w-1:0]       word_lo;
    logic [word_w-1:0]       word_hi;
    logic                    pair_now;
    logic [pair_w-1:0]       data_now;
    logic                    holding;
    logic [pair_w-1:0]       data_last;
    logic                    pair_last;

    // forwarded refill line or the hitting way
    assign line = choose_return ? mem_line : (choose_way ? rd_line1 : rd_line0);

    assign word_sel = req_vaddr[offset_width+1:2];
    assign next_sel = word_sel | offset_width'(1);

    // uncached word always returns in the low bits
    assign word_lo  = req_uncached ? mem_line[word_w-1:0] : line[word_sel*word_w +: word_w];
    assign word_hi  = line[next_sel*word_w +: word_w];
    // pair only from an even slot of a cached line
    assign pair_now = !req_uncached && !word_sel[0];
    assign data_now = pair_now ? {word_hi, word_lo} : {{word_w{1'b0}}, word_lo};

    ////////////////////
    // output hold
    ////////////////////

    // set by a response, kept while the fetch stage stays stalled
    always_ff @(posedge clk) begin
        if (!rstn) begin
            holding <= 1'b0;
        end else begin
            holding <= rsp_valid || (holding && fetch_hold);
        end
    end

    always_ff @(posedge clk) begin
        data_last <= rsp_data;
        pair_last <= rsp_pair;
    end

    // a refill can still finish while the fetch stage is stalled
    assign rsp_data = (holding && fetch_hold && !rsp_valid) ? data_last : data_now;
    assign rsp_pair = (holding && fetch_hold && !rsp_valid) ? pair_last : pair_now;
    assign rsp_pc   = req_vaddr;

endmodule

/* logic/icache_lru.sv */
`timescale 1ns/1ps

module icache_lru import icache_pkg::*; #(
    parameter int index_width = index_width_def
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] index,
    input  logic                   use_en,
    input  logic                   used_way,
    output logic                   victim
);

    localparam int sets = 1 << index_width;

    // bit points at the way to replace next
    logic [sets-1:0] lru_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use_en) begin
            lru_q[index] <= ~used_way;
        end
    end

    assign victim = lru_q[index];

endmodule

/* logic/icache_pkg.sv */
package icache_pkg;

    ////////////////////
    // cache geometry
    ////////////////////

    // set index bits, 16 sets by default
    localparam int index_width_def  = 4;

    // word-in-line bits, 4 words per line by default
    localparam int offset_width_def = 2;

    ////////////////////
    // fixed widths
    ////////////////////

    localparam int addr_w = 32;
    localparam int word_w = 32;

    // dual-issue response
    localparam int pair_w = 2 * word_w;

    // tied to the single LRU bit per set
    localparam int ways = 2;

endpackage

/* logic/icache_req_stage.sv */
`timescale 1ns/1ps

module icache_req_stage import icache_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              accept,
    input  logic [addr_w-1:0] fetch_vaddr,
    input  logic [addr_w-1:0] fetch_paddr,
    input  logic              fetch_uncached,
    output logic [addr_w-1:0] req_vaddr,
    output logic [addr_w-1:0] req_paddr,
    output logic              req_uncached
);

    logic pending;

    // request registers, loaded on accept and held otherwise
    always_ff @(posedge clk) begin
        if (accept) begin
            req_vaddr    <= fetch_vaddr;
            req_paddr    <= fetch_paddr;
            req_uncached <= fetch_uncached;
        end
    end

    // uncached request is in lookup and heads for memory next
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pending <= 1'b0;
        end else begin
            pending <= accept & fetch_uncached;
        end
    end

    // ctrl must keep the stage closed until memory answers
    a_no_accept_pending: assert property (
        @(posedge clk) disable iff (!rstn)
        pending |-> !accept
    );

endmodule

/* logic/icache_tagv.sv */
`timescale 1ns/1ps

module icache_tagv import icache_pkg::*; #(
    parameter  int index_width  = index_width_def,
    parameter  int offset_width = offset_width_def,
    localparam int tag_w        = addr_w - 2 - index_width - offset_width
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] rd_index,
    input  logic [tag_w-1:0]       cmp_tag,
    output logic [ways-1:0]        hit,
    output logic [ways-1:0]        valid_bits,
    input  logic [ways-1:0]        wr_en,
    input  logic [index_width-1:0] wr_index,
    input  logic [tag_w-1:0]       wr_tag,
    input  logic                   inv_en,
    input  logic [index_width-1:0] inv_index
);

    localparam int sets = 1 << index_width;

    for (genvar w = 0; w < ways; w++) begin : g_way
        logic [tag_w-1:0] tag_mem [sets];
        logic [sets-1:0]  valid_q;
        logic [tag_w-1:0] rd_tag;
        logic             rd_valid;

        // tag storage, read every cycle
        always_ff @(posedge clk) begin
            rd_tag <= tag_mem[rd_index];
            if (wr_en[w]) begin
                tag_mem[wr_index] <= wr_tag;
            end
        end

        // valid bits set on fill and cleared per set on invalidate
        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid_q  <= '0;
                rd_valid <= 1'b0;
            end else begin
                rd_valid <= valid_q[rd_index];
                if (inv_en) begin
                    valid_q[inv_index] <= 1'b0;
                end
                if (wr_en[w]) begin
                    valid_q[wr_index] <= 1'b1;
                end
            end
        end

        assign valid_bits[w] = rd_valid;
        // physical tag compare
        assign hit[w] = rd_valid && (rd_tag == cmp_tag);
    end

    // victim choice in ctrl never lets one line live in both ways
    a_one_way_hit: assert property (
        @(posedge clk) disable iff (!rstn)
        !(hit[0] && hit[1])
    );

endmodule

/* logic/icache_top.sv */
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter  int index_width  = index_width_def,
    parameter  int offset_width = offset_width_def,
    localparam int line_w       = word_w << offset_width,
    localparam int tag_lsb      = index_width + offset_width + 2
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   fetch_valid,
    input  logic [addr_w-1:0]      fetch_vaddr,
    input  logic [addr_w-1:0]      fetch_paddr,
    input  logic                   fetch_uncached,
    input  logic                   fetch_hold,
    input  logic                   op_valid,
    input  logic [index_width-1:0] op_index,
    output logic                   op_done,
    output logic                   rsp_valid,
    output logic [addr_w-1:0]      rsp_pc,
    output logic [pair_w-1:0]      rsp_data,
    output logic                   rsp_pair,
    output logic                   busy,
    output logic                   mem_req,
    output logic [addr_w-1:0]      mem_addr,
    output logic                   mem_uncached,
    input  logic [line_w-1:0]      mem_line,
    input  logic                   mem_data_ok
);

    logic [addr_w-1:0] req_vaddr;
    logic [addr_w-1:0] req_paddr;
    logic              req_uncached;
    logic              accept;
    logic [ways-1:0]   hit;
    logic [ways-1:0]   valid_bits;
    logic [ways-1:0]   fill_en;
    logic              victim;
    logic              use_en;
    logic              used_way;
    logic              inv_en;
    logic              choose_return;
    logic              choose_way;
    logic [line_w-1:0] rd_line0;
    logic [line_w-1:0] rd_line1;

    icache_req_stage u_req (
        .clk            (clk),
        .rstn           (rstn),
        .accept         (accept),
        .fetch_vaddr    (fetch_vaddr),
        .fetch_paddr    (fetch_paddr),
        .fetch_uncached (fetch_uncached),
        .req_vaddr      (req_vaddr),
        .req_paddr      (req_paddr),
        .req_uncached   (req_uncached)
    );

    // arrays read with the incoming virtual index
    icache_tagv #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_tagv (
        .clk        (clk),
        .rstn       (rstn),
        .rd_index   (fetch_vaddr[tag_lsb-1:offset_width+2]),
        .cmp_tag    (req_paddr[addr_w-1:tag_lsb]),
        .hit        (hit),
        .valid_bits (valid_bits),
        .wr_en      (fill_en),
        .wr_index   (req_vaddr[tag_lsb-1:offset_width+2]),
        .wr_tag     (req_paddr[addr_w-1:tag_lsb]),
        .inv_en     (inv_en),
        .inv_index  (op_index)
    );

    icache_data #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_data (
        .clk      (clk),
        .rd_index (fetch_vaddr[tag_lsb-1:offset_width+2]),
        .rd_line0 (rd_line0),
        .rd_line1 (rd_line1),
        .wr_en    (fill_en),
        .wr_index (req_vaddr[tag_lsb-1:offset_width+2]),
        .wr_line  (mem_line)
    );

    icache_lru #(
        .index_width (index_width)
    ) u_lru (
        .clk      (clk),
        .rstn     (rstn),
        .index    (req_vaddr[tag_lsb-1:offset_width+2]),
        .use_en   (use_en),
        .used_way (used_way),
        .victim   (victim)
    );

    icache_ctrl #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_valid   (fetch_valid),
        .fetch_hold    (fetch_hold),
        .op_valid      (op_valid),
        .op_index      (op_index),
        .req_vaddr     (req_vaddr),
        .req_paddr     (req_paddr),
        .req_uncached  (req_uncached),
        .hit           (hit),
        .valid_bits    (valid_bits),
        .victim        (victim),
        .accept        (accept),
        .busy          (busy),
        .rsp_valid     (rsp_valid),
        .op_done       (op_done),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_uncached  (mem_uncached),
        .mem_data_ok   (mem_data_ok),
        .fill_en       (fill_en),
        .use_en        (use_en),
        .used_way      (used_way),
        .inv_en        (inv_en),
        .choose_return (choose_return),
        .choose_way    (choose_way)
    );

    icache_fetch_select #(
        .offset_width (offset_width)
    ) u_sel (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_hold    (fetch_hold),
        .rsp_valid     (rsp_valid),
        .choose_return (choose_return),
        .choose_way    (choose_way),
        .req_vaddr     (req_vaddr),
        .req_uncached  (req_uncached),
        .rd_line0      (rd_line0),
        .rd_line1      (rd_line1),
        .mem_line      (mem_line),
        .rsp_pc        (rsp_pc),
        .rsp_data      (rsp_data),
        .rsp_pair      (rsp_pair)
    );

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f build.f \
    -o sim_icache || exit 1
./obj_dir/sim_icache > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1
grep -qF "*** TEST PASSED ***" sim.log && exit 0
exit 1
